// File: hw/m6502_pkg.sv
`default_nettype none

package m6502_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;  // Low byte, high byte at +1

   // Fetch unit states
   localparam logic [2:0] F_RESET  = 3'd0;
   localparam logic [2:0] F_VEC_LO = 3'd1;
   localparam logic [2:0] F_VEC_HI = 3'd2;
   localparam logic [2:0] F_OPCODE = 3'd3;
   localparam logic [2:0] F_OP1    = 3'd4;
   localparam logic [2:0] F_OP2    = 3'd5;
   localparam logic [2:0] F_HOLD   = 3'd6;  // Instruction offered to execute

   // Execute unit states
   localparam logic [1:0] E_IDLE = 2'd0;
   localparam logic [1:0] E_MEM  = 2'd1;   // Operand load or store on the bus
   localparam logic [1:0] E_DONE = 2'd2;   // Implied or immediate write-back

   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [2:0] aaa;
         logic [2:0] bbb;
         logic [1:0] cc;
      } f;
   } opcode_u;

   typedef enum logic [4:0] {
      OP_NOP, OP_LDA, OP_LDX, OP_LDY,
      OP_STA, OP_STX, OP_STY,
      OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_SBC,
      OP_CMP, OP_CPX, OP_CPY,
      OP_INX, OP_INY, OP_DEX, OP_DEY,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA,
      OP_CLC, OP_SEC, OP_BRANCH
   } op_e;

   typedef enum logic [1:0] {
      MODE_IMPLIED,
      MODE_IMM,
      MODE_ZP,
      MODE_ABS
   } mode_e;

   typedef enum logic [2:0] {
      ALU_PASS,
      ALU_OR,
      ALU_AND,
      ALU_EOR,
      ALU_ADC,
      ALU_CMP,
      ALU_INC,
      ALU_DEC
   } alu_op_e;

endpackage

`default_nettype wire

// File: hw/m6502_alu.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_alu (
   input  m6502_pkg::alu_op_e           op,
   input  logic [m6502_pkg::DATA_W-1:0] a,
   input  logic [m6502_pkg::DATA_W-1:0] b,
   input  logic                         carry_in,
   output logic [m6502_pkg::DATA_W-1:0] result,
   output logic                         n,
   output logic                         z,
   output logic                         c,
   output logic                         v
);
   import m6502_pkg::*;

   logic [DATA_W:0] sum;
   logic [DATA_W:0] diff;

   assign sum  = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, carry_in};
   assign diff = {1'b0, a} - {1'b0, b};

   always_comb
   begin
      result = a;
      c      = carry_in;
      v      = 1'b0;
      case (op)
         ALU_PASS: result = a;
         ALU_OR:   result = a | b;
         ALU_AND:  result = a & b;
         ALU_EOR:  result = a ^ b;
         ALU_ADC:
         begin
            result = sum[DATA_W-1:0];
            c      = sum[DATA_W];
            v      = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
         end
         ALU_CMP:
         begin
            result = diff[DATA_W-1:0];
            c      = !diff[DATA_W];  // No borrow means a >= b
         end
         ALU_INC:  result = a + 1'b1;
         ALU_DEC:  result = a - 1'b1;
      endcase
   end

   assign n = result[DATA_W-1];
   assign z = (result == '0);

endmodule

`default_nettype wire

// File: hw/m6502_decode.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_decode (
   input  m6502_pkg::opcode_u opcode,
   output m6502_pkg::op_e     op,
   output m6502_pkg::mode_e   mode,
   output logic [1:0]         length
);
   import m6502_pkg::*;

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic       grp_ok;
   mode_e      grp_mode;  // Mode column shared by cc = 00 and cc = 10

   assign aaa = opcode.f.aaa;
   assign bbb = opcode.f.bbb;

   always_comb
   begin
      grp_ok   = 1'b1;
      grp_mode = MODE_IMPLIED;
      case (bbb)
         3'd0: grp_mode = MODE_IMM;
         3'd1: grp_mode = MODE_ZP;
         3'd3: grp_mode = MODE_ABS;
         default: grp_ok = 1'b0;
      endcase
   end

   always_comb
   begin
      op   = OP_NOP;
      mode = MODE_IMPLIED;
      case (opcode.f.cc)
         2'b01:
            if (bbb == 3'd1 || bbb == 3'd2 || bbb == 3'd3)
            begin
               case (aaa)
                  3'd0: op = OP_ORA;
                  3'd1: op = OP_AND;
                  3'd2: op = OP_EOR;
                  3'd3: op = OP_ADC;
                  3'd4: op = (bbb == 3'd2) ? OP_NOP : OP_STA;  // No STA immediate
                  3'd5: op = OP_LDA;
                  3'd6: op = OP_CMP;
                  default: op = OP_SBC;
               endcase
               if (op != OP_NOP)
                  mode = (bbb == 3'd2) ? MODE_IMM : (bbb == 3'd1) ? MODE_ZP : MODE_ABS;
            end
         2'b10:
            if (bbb == 3'd2)
            begin
               case (aaa)
                  3'd4: op = OP_TXA;
                  3'd5: op = OP_TAX;
                  3'd6: op = OP_DEX;
                  default: op = OP_NOP;  // Shifts on A dropped
               endcase
            end
            else if (grp_ok)
            begin
               if (aaa == 3'd5)
                  op = OP_LDX;
               else if (aaa == 3'd4 && grp_mode != MODE_IMM)
                  op = OP_STX;
               if (op != OP_NOP)
                  mode = grp_mode;
            end
         2'b00:
            if (bbb == 3'd4)
            begin
               op   = OP_BRANCH;
               mode = MODE_IMM;  // Offset byte
            end
            else if (bbb == 3'd6)
            begin
               case (aaa)
                  3'd0: op = OP_CLC;
                  3'd1: op = OP_SEC;
                  3'd4: op = OP_TYA;
                  default: op = OP_NOP;
               endcase
            end
            else if (bbb == 3'd2)
            begin
               case (aaa)
                  3'd4: op = OP_DEY;
                  3'd5: op = OP_TAY;
                  3'd6: op = OP_INY;
                  3'd7: op = OP_INX;
                  default: op = OP_NOP;
               endcase
            end
            else if (grp_ok)
            begin
               case (aaa)
                  3'd4: op = (grp_mode == MODE_IMM) ? OP_NOP : OP_STY;
                  3'd5: op = OP_LDY;
                  3'd6: op = OP_CPY;
                  3'd7: op = OP_CPX;
                  default: op = OP_NOP;
               endcase
               if (op != OP_NOP)
                  mode = grp_mode;
            end
         default: op = OP_NOP;
      endcase
   end

   assign length = (mode == MODE_ABS) ? 2'd3 : (mode == MODE_IMPLIED) ? 2'd1 : 2'd2;

endmodule

`default_nettype wire

// File: hw/m6502_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_fetch (
   input  logic                         clk,
   input  logic                         reset_n,
   output logic                         f_valid,
   output logic [m6502_pkg::ADDR_W-1:0] f_addr,
   input  logic                         f_ready,
   input  logic [m6502_pkg::DATA_W-1:0] rdata,
   output logic                         inst_valid,
   output m6502_pkg::op_e               inst_op,
   output m6502_pkg::mode_e             inst_mode,
   output logic [m6502_pkg::ADDR_W-1:0] inst_operand,
   output logic [m6502_pkg::ADDR_W-1:0] inst_next_pc,
   input  logic                         inst_ready,
   input  logic                         redirect,
   input  logic [m6502_pkg::ADDR_W-1:0] redirect_pc
);
   import m6502_pkg::*;

   logic [2:0]        state;
   logic [ADDR_W-1:0] pc;
   logic              drain;      // Redirect seen while a read was outstanding
   logic [ADDR_W-1:0] target;
   logic              fire;
   logic              pending;
   opcode_u           cur_opcode;
   op_e               dec_op;
   mode_e             dec_mode;
   logic [1:0]        dec_len;
   op_e               op_q;
   mode_e             mode_q;
   logic [1:0]        len_q;
   logic [ADDR_W-1:0] operand_q;  // High byte keeps the opcode for 2-byte instructions

   assign cur_opcode.raw = rdata;

   m6502_decode u_decode (
      .opcode (cur_opcode),
      .op     (dec_op),
      .mode   (dec_mode),
      .length (dec_len)
   );

   assign f_valid = (state != F_RESET) && (state != F_HOLD);
   assign f_addr  = pc;
   assign fire    = f_valid && f_ready;
   assign pending = f_valid && !f_ready;

   assign inst_valid   = (state == F_HOLD);
   assign inst_op      = op_q;
   assign inst_mode    = mode_q;
   assign inst_operand = operand_q;
   assign inst_next_pc = pc;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state <= F_RESET;
         pc    <= RESET_VECTOR;
         drain <= 1'b0;
      end
      else if (redirect && !pending)
      begin
         state <= F_OPCODE;  // Buffered instruction dropped
         pc    <= redirect_pc;
         drain <= 1'b0;
      end
      else if (redirect)
         drain <= 1'b1;
      else if (drain)
      begin
         if (fire)
         begin
            drain <= 1'b0;  // Stale byte discarded
            pc    <= target;
            state <= F_OPCODE;
         end
      end
      else
      begin
         case (state)
            F_RESET: state <= F_VEC_LO;
            F_VEC_LO:
               if (fire)
               begin
                  pc    <= pc + 1'b1;
                  state <= F_VEC_HI;
               end
            F_VEC_HI:
               if (fire)
               begin
                  pc    <= {rdata, operand_q[DATA_W-1:0]};
                  state <= F_OPCODE;
               end
            F_OPCODE:
               if (fire)
               begin
                  pc    <= pc + 1'b1;
                  state <= (dec_len == 2'd1) ? F_HOLD : F_OP1;
               end
            F_OP1:
               if (fire)
               begin
                  pc    <= pc + 1'b1;
                  state <= (len_q == 2'd3) ? F_OP2 : F_HOLD;
               end
            F_OP2:
               if (fire)
               begin
                  pc    <= pc + 1'b1;
                  state <= F_HOLD;
               end
            default:
               if (inst_ready)
                  state <= F_OPCODE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (redirect)
         target <= redirect_pc;
      if (fire && (state == F_OPCODE))
      begin
         op_q                    <= dec_op;
         mode_q                  <= dec_mode;
         len_q                   <= dec_len;
         operand_q[ADDR_W-1:DATA_W] <= rdata;
      end
      if (fire && (state == F_VEC_LO || state == F_OP1))
         operand_q[DATA_W-1:0] <= rdata;
      if (fire && (state == F_OP2))
         operand_q[ADDR_W-1:DATA_W] <= rdata;
   end

endmodule

`default_nettype wire

// File: hw/m6502_execute.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_execute (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         inst_valid,
   output logic                         inst_ready,
   input  m6502_pkg::op_e               inst_op,
   input  m6502_pkg::mode_e             inst_mode,
   input  logic [m6502_pkg::ADDR_W-1:0] inst_operand,
   input  logic [m6502_pkg::ADDR_W-1:0] inst_next_pc,
   output logic                         e_valid,
   output logic                         e_we,
   output logic [m6502_pkg::ADDR_W-1:0] e_addr,
   output logic [m6502_pkg::DATA_W-1:0] e_wdata,
   input  logic                         e_ready,
   input  logic [m6502_pkg::DATA_W-1:0] rdata,
   output logic                         redirect,
   output logic [m6502_pkg::ADDR_W-1:0] redirect_pc
);
   import m6502_pkg::*;

   logic [1:0]        state;
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] x;
   logic [DATA_W-1:0] y;
   logic              n;
   logic              z;
   logic              c;
   logic              v;
   op_e               op_q;
   mode_e             mode_q;
   logic [ADDR_W-1:0] operand_q;
   logic [ADDR_W-1:0] next_pc_q;
   logic              accept;
   logic              done;
   logic [DATA_W-1:0] opnd;
   alu_op_e           alu_op;
   logic [DATA_W-1:0] alu_a;
   logic [DATA_W-1:0] alu_b;
   logic              alu_cin;
   logic [DATA_W-1:0] alu_result;
   logic              alu_n;
   logic              alu_z;
   logic              alu_c;
   logic              alu_v;
   logic              wr_a;
   logic              wr_x;
   logic              wr_y;
   logic              wr_cmp;
   logic              wr_c;
   logic              wr_v;
   logic              taken;
   logic              flag;

   assign inst_ready = (state == E_IDLE);
   assign accept     = inst_valid && inst_ready;
   assign done       = (state == E_DONE) || ((state == E_MEM) && e_ready);
   assign opnd       = (state == E_MEM) ? rdata : operand_q[DATA_W-1:0];

   assign e_valid = (state == E_MEM);
   assign e_we    = op_q inside {OP_STA, OP_STX, OP_STY};
   assign e_addr  = (mode_q == MODE_ZP) ?
                    {{(ADDR_W-DATA_W){1'b0}}, operand_q[DATA_W-1:0]} : operand_q;
   assign e_wdata = (op_q == OP_STX) ? x : (op_q == OP_STY) ? y : a;

   always_comb
   begin
      case (op_q)
         OP_ORA: alu_op = ALU_OR;
         OP_AND: alu_op = ALU_AND;
         OP_EOR: alu_op = ALU_EOR;
         OP_ADC, OP_SBC: alu_op = ALU_ADC;
         OP_CMP, OP_CPX, OP_CPY: alu_op = ALU_CMP;
         OP_INX, OP_INY: alu_op = ALU_INC;
         OP_DEX, OP_DEY: alu_op = ALU_DEC;
         default: alu_op = ALU_PASS;
      endcase
      case (op_q)
         OP_TAX, OP_TAY, OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_SBC, OP_CMP: alu_a = a;
         OP_TXA, OP_CPX, OP_INX, OP_DEX: alu_a = x;
         OP_TYA, OP_CPY, OP_INY, OP_DEY: alu_a = y;
         default: alu_a = opnd;
      endcase
   end

   assign alu_b   = (op_q == OP_SBC) ? ~opnd : opnd;
   assign alu_cin = (op_q == OP_SEC) || (c && (op_q != OP_CLC));  // CLC/SEC go through PASS

   assign wr_a   = op_q inside {OP_LDA, OP_TXA, OP_TYA, OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_SBC};
   assign wr_x   = op_q inside {OP_LDX, OP_TAX, OP_INX, OP_DEX};
   assign wr_y   = op_q inside {OP_LDY, OP_TAY, OP_INY, OP_DEY};
   assign wr_cmp = op_q inside {OP_CMP, OP_CPX, OP_CPY};
   assign wr_c   = wr_cmp || (op_q inside {OP_ADC, OP_SBC, OP_CLC, OP_SEC});
   assign wr_v   = op_q inside {OP_ADC, OP_SBC};

   m6502_alu u_alu (
      .op       (alu_op),
      .a        (alu_a),
      .b        (alu_b),
      .carry_in (alu_cin),
      .result   (alu_result),
      .n        (alu_n),
      .z        (alu_z),
      .c        (alu_c),
      .v        (alu_v)
   );

   // Branch condition from opcode bits 7:5 kept in the operand high byte
   always_comb
   begin
      case (operand_q[ADDR_W-1:ADDR_W-2])
         2'd0: flag = n;
         2'd1: flag = v;
         2'd2: flag = c;
         default: flag = z;
      endcase
   end

   assign taken       = (flag == operand_q[ADDR_W-1-2]);
   assign redirect    = (state == E_DONE) && (op_q == OP_BRANCH) && taken;
   assign redirect_pc = next_pc_q +
                        {{(ADDR_W-DATA_W){operand_q[DATA_W-1]}}, operand_q[DATA_W-1:0]};

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state <= E_IDLE;
         a     <= '0;
         x     <= '0;
         y     <= '0;
         n     <= 1'b0;
         z     <= 1'b0;
         c     <= 1'b0;
         v     <= 1'b0;
      end
      else
      begin
         if (accept)
            state <= (inst_mode == MODE_ZP || inst_mode == MODE_ABS) ? E_MEM : E_DONE;
         else if (done)
            state <= E_IDLE;
         if (done)
         begin
            if (wr_a)
               a <= alu_result;
            if (wr_x)
               x <= alu_result;
            if (wr_y)
               y <= alu_result;
            if (wr_a || wr_x || wr_y || wr_cmp)
            begin
               n <= alu_n;
               z <= alu_z;
            end
            if (wr_c)
               c <= alu_c;
            if (wr_v)
               v <= alu_v;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q      <= inst_op;
         mode_q    <= inst_mode;
         operand_q <= inst_operand;
         next_pc_q <= inst_next_pc;
      end
   end

endmodule

`default_nettype wire

// File: hw/m6502_bus_arb.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_bus_arb (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         f_valid,
   input  logic [m6502_pkg::ADDR_W-1:0] f_addr,
   output logic                         f_ready,
   input  logic                         e_valid,
   input  logic                         e_we,
   input  logic [m6502_pkg::ADDR_W-1:0] e_addr,
   input  logic [m6502_pkg::DATA_W-1:0] e_wdata,
   output logic                         e_ready,
   output logic                         mem_valid,
   output logic                         mem_we,
   output logic [m6502_pkg::ADDR_W-1:0] mem_addr,
   output logic [m6502_pkg::DATA_W-1:0] mem_wdata,
   input  logic                         mem_ready
);

   logic busy;
   logic owner_e;
   logic sel_e;

   assign sel_e = busy ? owner_e : e_valid;  // Execute first when idle

   assign mem_valid = sel_e ? e_valid : f_valid;
   assign mem_we    = sel_e && e_we;
   assign mem_addr  = sel_e ? e_addr : f_addr;
   assign mem_wdata = sel_e ? e_wdata : '0;
   assign e_ready   = sel_e && mem_ready;
   assign f_ready   = !sel_e && mem_ready;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         busy    <= 1'b0;
         owner_e <= 1'b0;
      end
      else if (mem_valid && mem_ready)
         busy <= 1'b0;
      else if (mem_valid)
      begin
         busy    <= 1'b1;  // Hold winner through the wait
         owner_e <= sel_e;
      end
   end

endmodule

`default_nettype wire

// File: hw/m6502_top.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_top (
   input  logic                         clk,
   input  logic                         reset_n,
   output logic                         mem_valid,
   output logic                         mem_we,
   output logic [m6502_pkg::ADDR_W-1:0] mem_addr,
   output logic [m6502_pkg::DATA_W-1:0] mem_wdata,
   input  logic                         mem_ready,
   input  logic [m6502_pkg::DATA_W-1:0] mem_rdata
);
   import m6502_pkg::*;

   logic              f_valid;
   logic              f_ready;
   logic [ADDR_W-1:0] f_addr;
   logic              e_valid;
   logic              e_ready;
   logic              e_we;
   logic [ADDR_W-1:0] e_addr;
   logic [DATA_W-1:0] e_wdata;
   logic              inst_valid;
   logic              inst_ready;
   op_e               inst_op;
   mode_e             inst_mode;
   logic [ADDR_W-1:0] inst_operand;
   logic [ADDR_W-1:0] inst_next_pc;
   logic              redirect;
   logic [ADDR_W-1:0] redirect_pc;

   m6502_fetch u_fetch (
      .clk          (clk),
      .reset_n      (reset_n),
      .f_valid      (f_valid),
      .f_addr       (f_addr),
      .f_ready      (f_ready),
      .rdata        (mem_rdata),
      .inst_valid   (inst_valid),
      .inst_op      (inst_op),
      .inst_mode    (inst_mode),
      .inst_operand (inst_operand),
      .inst_next_pc (inst_next_pc),
      .inst_ready   (inst_ready),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc)
   );

   m6502_execute u_execute (
      .clk          (clk),
      .reset_n      (reset_n),
      .inst_valid   (inst_valid),
      .inst_ready   (inst_ready),
      .inst_op      (inst_op),
      .inst_mode    (inst_mode),
      .inst_operand (inst_operand),
      .inst_next_pc (inst_next_pc),
      .e_valid      (e_valid),
      .e_we         (e_we),
      .e_addr       (e_addr),
      .e_wdata      (e_wdata),
      .e_ready      (e_ready),
      .rdata        (mem_rdata),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc)
   );

   m6502_bus_arb u_bus_arb (
      .clk       (clk),
      .reset_n   (reset_n),
      .f_valid   (f_valid),
      .f_addr    (f_addr),
      .f_ready   (f_ready),
      .e_valid   (e_valid),
      .e_we      (e_we),
      .e_addr    (e_addr),
      .e_wdata   (e_wdata),
      .e_ready   (e_ready),
      .mem_valid (mem_valid),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ready (mem_ready)
   );

endmodule

`default_nettype wire

// File: sim/m6502_bus_sva.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_bus_sva (
   input logic                         clk,
   input logic                         reset_n,
   input logic                         f_ready,
   input logic                         e_ready,
   input logic                         mem_valid,
   input logic                         mem_we,
   input logic [m6502_pkg::ADDR_W-1:0] mem_addr,
   input logic [m6502_pkg::DATA_W-1:0] mem_wdata,
   input logic                         mem_ready
);

   // Waiting request must not move
   held_stable: assert property (@(posedge clk) disable iff (!reset_n)
      (mem_valid && !mem_ready) |=>
         (mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
      else $error("bus request changed while mem_ready was low");

   one_grant: assert property (@(posedge clk) disable iff (!reset_n)
      !(f_ready && e_ready))
      else $error("fetch and execute both granted in one cycle");

   idle_after_reset: assert property (@(posedge clk)
      !reset_n |=> !mem_valid)
      else $error("mem_valid high right after reset");

endmodule

bind m6502_bus_arb m6502_bus_sva u_bus_sva (
   .clk       (clk),
   .reset_n   (reset_n),
   .f_ready   (f_ready),
   .e_ready   (e_ready),
   .mem_valid (mem_valid),
   .mem_we    (mem_we),
   .mem_addr  (mem_addr),
   .mem_wdata (mem_wdata),
   .mem_ready (mem_ready)
);

`default_nettype wire

// File: sim/m6502_tb.sv
`timescale 1ns/100ps
`default_nettype none

module m6502_tb;
   import m6502_pkg::*;

   localparam int          NUM_ROWS       = 13;
   localparam int          TIMEOUT_CYCLES = NUM_ROWS * 400;
   localparam logic [15:0] PROG_BASE      = 16'h0200;
   localparam logic [15:0] ZP_PRESET      = 16'h0010;
   localparam logic [15:0] ABS_PRESET     = 16'h0340;

   logic              clk;
   logic              reset_n;
   logic              mem_valid;
   logic              mem_we;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic              mem_ready;
   logic [DATA_W-1:0] mem_rdata;

   logic [7:0]  mem [0:65535];
   logic [7:0]  lfsr;
   int          cycles;
   int          xfer_idx;   // Transfers since reset release
   logic        wr_seen;
   logic [15:0] wr_addr;
   logic [7:0]  wr_data;
   int          row;
   int          row_count;
   int          wr_errors;
   int          vec_errors;

   string       names [NUM_ROWS];
   logic [95:0] programs [NUM_ROWS];  // First byte in the top bits
   logic [7:0]  zp_data [NUM_ROWS];
   logic [7:0]  abs_data [NUM_ROWS];
   logic [15:0] exp_addr [NUM_ROWS];
   logic [7:0]  exp_data [NUM_ROWS];

   m6502_top dut (
      .clk       (clk),
      .reset_n   (reset_n),
      .mem_valid (mem_valid),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata)
   );

   assign mem_rdata = mem[mem_addr];  // Read data in the handshake cycle

   always #20 clk = ~clk;

   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   always @(posedge clk)
   begin
      #2;
      lfsr      = lfsr_next(lfsr);
      mem_ready = lfsr[0];
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, test %0d never wrote to memory", cycles, row);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Bus monitor, outputs settled well before the next rising edge
   always @(negedge clk)
   begin
      logic [15:0] vec_exp;
      if (reset_n && mem_valid && mem_ready)
      begin
         if (mem_we)
         begin
            if (!wr_seen)
            begin
               wr_addr = mem_addr;
               wr_data = mem_wdata;
            end
            wr_seen       = 1'b1;
            mem[mem_addr] = mem_wdata;
         end
         else if (xfer_idx < 2)
         begin
            vec_exp = (xfer_idx == 0) ? 16'hFFFC : 16'hFFFD;
            assert (mem_addr == vec_exp)
            else
            begin
               $display("CHECK FAILED %s: vector read %0d expected %h actual %h",
                        names[row], xfer_idx, vec_exp, mem_addr);
               vec_errors++;
            end
         end
         xfer_idx++;
      end
   end

   task automatic add_test(input string name, input logic [95:0] code, input logic [7:0] zp,
                           input logic [7:0] ab, input logic [15:0] addr,
                           input logic [7:0] data);
      names[row_count]    = name;
      programs[row_count] = code;
      zp_data[row_count]  = zp;
      abs_data[row_count] = ab;
      exp_addr[row_count] = addr;
      exp_data[row_count] = data;
      row_count++;
   endtask

   task automatic load_memory(input int r);
      int          i;
      int          k;
      logic [15:0] a;
      for (i = 0; i < 65536; i++)
      begin
         a      = i[15:0];
         mem[i] = a[15:8] ^ a[7:0] ^ 8'h5A;
      end
      mem[16'hFFFC] = PROG_BASE[7:0];
      mem[16'hFFFD] = PROG_BASE[15:8];
      for (k = 0; k < 12; k++)
         mem[PROG_BASE + k] = programs[r][95-8*k -: 8];
      mem[ZP_PRESET]  = zp_data[r];
      mem[ABS_PRESET] = abs_data[r];
   endtask

   task automatic run_test(input int r);
      @(posedge clk);
      #2;
      reset_n = 1'b0;
      load_memory(r);
      wr_seen  = 1'b0;
      xfer_idx = 0;
      repeat (5) @(posedge clk);
      #2;
      reset_n = 1'b1;
      while (!wr_seen)
         @(posedge clk);
      assert (wr_addr == exp_addr[r])
      else
      begin
         $display("CHECK FAILED %s: write address expected %h actual %h",
                  names[r], exp_addr[r], wr_addr);
         wr_errors++;
      end
      assert (wr_data == exp_data[r])
      else
      begin
         $display("CHECK FAILED %s: write data expected %h actual %h",
                  names[r], exp_data[r], wr_data);
         wr_errors++;
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      reset_n    = 1'b0;
      mem_ready  = 1'b0;
      lfsr       = 8'd45;
      cycles     = 0;
      wr_seen    = 1'b0;
      xfer_idx   = 0;
      wr_errors  = 0;
      vec_errors = 0;
      row        = 0;
      row_count  = 0;

      add_test("lda_sta", 96'hA9_5A_8D_80_00_EA_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0080, 8'h5A);
      add_test("adc", 96'h18_A9_37_69_5C_85_80_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0080, 8'h37 + 8'h5C);
      add_test("sbc", 96'h38_A9_50_E9_70_85_81_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0081, 8'h50 - 8'h70);
      add_test("and", 96'hA9_F0_29_3C_85_82_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0082, 8'hF0 & 8'h3C);
      add_test("ora", 96'hA9_0F_09_30_85_83_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0083, 8'h0F | 8'h30);
      add_test("eor", 96'hA9_FF_49_A5_85_84_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0084, 8'hFF ^ 8'hA5);
      add_test("ldx_zp_txa", 96'hA6_10_8A_8D_00_03_EA_EA_EA_EA_EA_EA,
               8'hC3, 8'h00, 16'h0300, 8'hC3);
      add_test("ldy_abs_tya", 96'hAC_40_03_98_85_85_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h7E, 16'h0085, 8'h7E);
      add_test("iny_dey", 96'hA0_7F_C8_C8_88_98_85_86_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0086, 8'h7F + 8'd1 + 8'd1 - 8'd1);
      add_test("dex_wrap", 96'hA2_00_CA_8A_85_87_EA_EA_EA_EA_EA_EA,
               8'h00, 8'h00, 16'h0087, 8'h00 - 8'd1);
      // A holds 11, X holds 22, taken branch skips the STA
      add_test("beq_equal", 96'hA9_11_A2_22_C9_11_F0_02_85_88_86_88,
               8'h00, 8'h00, 16'h0088, 8'h22);
      add_test("beq_unequal", 96'hA9_11_A2_22_C9_12_F0_02_85_88_86_88,
               8'h00, 8'h00, 16'h0088, 8'h11);
      add_test("bcc_after_sec", 96'hA2_22_A9_11_38_EA_90_02_85_89_86_89,
               8'h00, 8'h00, 16'h0089, 8'h11);  // Carry set so no branch
      load_memory(0);

      for (row = 0; row < row_count; row++)
         run_test(row);

      $display("Errors: %0d write, %0d vector, %0d tests run",
               wr_errors, vec_errors, row_count);
      if (wr_errors + vec_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
hw/m6502_pkg.sv
hw/m6502_alu.sv
hw/m6502_decode.sv
hw/m6502_fetch.sv
hw/m6502_execute.sv
hw/m6502_bus_arb.sv
hw/m6502_top.sv
sim/m6502_bus_sva.sv
sim/m6502_tb.sv

// File: Bender.yml
package:
  name: m6502

sources:
  - hw/m6502_pkg.sv
  - hw/m6502_alu.sv
  - hw/m6502_decode.sv
  - hw/m6502_fetch.sv
  - hw/m6502_execute.sv
  - hw/m6502_bus_arb.sv
  - hw/m6502_top.sv
  - target: test
    files:
      - sim/m6502_bus_sva.sv
      - sim/m6502_tb.sv
